// File: hdl/lsu_cfg_pkg.sv
package lsu_cfg_pkg;

    // ----------------------------------------------------------
    // Widths and counts
    // ----------------------------------------------------------
    localparam int ADDR_W    = 32;  // Byte address
    localparam int WORD_W    = 32;  // External beat
    localparam int LANES     = 4;   // Lanes per vector
    localparam int VEC_W     = 128; // Full vector register
    localparam int REG_IDX_W = 5;   // Destination register index
    localparam int LANE_W    = 2;   // Lane and beat counters

    // Outstanding loads tracked in order
    localparam int TAG_DEPTH = 8;
    localparam int TAG_PTR_W = $clog2(TAG_DEPTH);

    // ----------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------
    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [WORD_W-1:0] word_t;

    // Lane 0 sits in the low word
    typedef logic [VEC_W-1:0] vec_t;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef logic [LANE_W-1:0] lane_t;

endpackage

// File: hdl/lsu_bus_pkg.sv
package lsu_bus_pkg;

    import lsu_cfg_pkg::*;

    // ----------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------

    // Lane addressing of a vector access
    typedef enum logic [1:0] {
        UNIT    = 2'd0, // Consecutive words
        STRIDE  = 2'd1, // Base plus stride per lane
        INDEXED = 2'd2  // Base plus per-lane offset
    } vec_mode_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0, // Beat 0 passes straight through
        BEATS = 2'd1  // Beats 1 to 3 of a vector
    } adapt_state_e;

    // ----------------------------------------------------------
    // Internal buses
    // ----------------------------------------------------------

    // Arbitrated 128-bit request
    typedef struct packed {
        logic      is_load;
        logic      is_vector;
        logic      is_tex;    // Texture refill
        addr_t     addr;      // Aligned for vectors
        vec_t      wdata;
        reg_idx_t  rd;
        vec_mode_e mode;
        addr_t     stride;    // Byte stride for STRIDE mode
        vec_t      index;     // Per-lane offsets for INDEXED mode
    } mem_req_t;

    // One entry per outstanding load
    typedef struct packed {
        logic     is_vector;
        logic     is_tex;
        reg_idx_t rd;
    } load_tag_t;

    // Completed load
    typedef struct packed {
        logic     is_vector;
        logic     is_tex;
        reg_idx_t rd;
        vec_t     data;
    } load_rsp_t;

endpackage

// File: hdl/lsu_issue.sv
module lsu_issue
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Pipeline
    input  logic      valid_in,
    input  logic      is_vector,
    input  logic      is_store,
    input  vec_mode_e vec_mode,
    input  addr_t     vec_stride,
    input  vec_t      vec_index,
    input  addr_t     addr,
    input  vec_t      write_data,
    input  reg_idx_t  dest_reg_idx,
    // Texture refill
    input  logic      tex_req_valid,
    input  addr_t     tex_req_addr,
    // Adapter side
    input  logic      req_ready,
    input  logic      rsp_valid,
    input  load_rsp_t rsp,
    output logic      req_valid,
    output mem_req_t  req,
    output logic      tex_req_ready,
    output logic      stall_pipeline,
    output logic      scalar_wait
);

    logic     pipe_valid;
    logic     pipe_grant;
    logic     scalar_load;
    logic     scalar_done;
    addr_t    addr_eff;
    reg_idx_t pending_rd;

    // ----------------------------------------------------------
    // Request selection, texture first
    // ----------------------------------------------------------
    assign addr_eff    = is_vector ? {addr[ADDR_W-1:4], 4'b0} : addr; // 16-byte aligned
    assign scalar_load = valid_in && !is_vector && !is_store;

    // Pipeline only goes when no refill is pending and no scalar load blocks
    assign pipe_valid = valid_in && !scalar_wait && !tex_req_valid;

    assign req_valid     = tex_req_valid || pipe_valid;
    assign tex_req_ready = tex_req_valid && req_ready;
    assign pipe_grant    = pipe_valid && req_ready;

    always_comb begin
        if (tex_req_valid) begin
            req.is_load   = 1'b1;
            req.is_vector = 1'b1;
            req.is_tex    = 1'b1;
            req.addr      = tex_req_addr;
            req.wdata     = '0;
            req.rd        = '0;
            req.mode      = UNIT; // Refills are always unit stride
            req.stride    = '0;
            req.index     = '0;
        end else begin
            req.is_load   = !is_store;
            req.is_vector = is_vector;
            req.is_tex    = 1'b0;
            req.addr      = addr_eff;
            req.wdata     = is_vector ? write_data : vec_t'(write_data[WORD_W-1:0]);
            req.rd        = dest_reg_idx;
            req.mode      = vec_mode;
            req.stride    = vec_stride;
            req.index     = vec_index;
        end
    end

    // ----------------------------------------------------------
    // Scalar load blocking
    // ----------------------------------------------------------

    // Release on the non-texture scalar response for the waiting register
    assign scalar_done = rsp_valid && !rsp.is_tex && !rsp.is_vector
                      && (rsp.rd == pending_rd);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scalar_wait <= 1'b0;
        end else if (pipe_grant && scalar_load) begin
            scalar_wait <= 1'b1;
        end else if (scalar_wait && scalar_done) begin
            scalar_wait <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_grant && scalar_load) begin
            pending_rd <= dest_reg_idx;
        end
    end

    // Issuing cycle of a scalar load stalls as well
    assign stall_pipeline = scalar_wait
                         || (valid_in && !pipe_grant)
                         || scalar_load;

endmodule

// File: hdl/lsu_beat_adapter.sv
module lsu_beat_adapter
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  mem_req_t  req,
    input  logic      global_req_ready,
    input  logic      tag_full,
    output logic      req_ready,
    // External 32-bit port
    output logic      global_req_valid,
    output logic      global_req_is_load,
    output addr_t     global_req_addr,
    output word_t     global_req_wdata,
    // Tag FIFO push
    output logic      tag_push,
    output load_tag_t tag_in,
    output logic      active
);

    adapt_state_e state;
    lane_t        beat;  // Next beat to send while in BEATS
    mem_req_t     hold;  // Accepted vector request
    logic         room;
    logic         accept;

    // Address of one lane under the request's addressing mode
    function automatic addr_t lane_addr(input mem_req_t r, input lane_t lane);
        addr_t a;
        if (!r.is_vector) begin
            a = r.addr;
        end else if (r.is_tex) begin
            a = r.addr + addr_t'(lane) * addr_t'(4);
        end else begin
            case (r.mode)
                STRIDE:  a = r.addr + r.stride * addr_t'(lane);
                INDEXED: a = r.addr + r.index[lane*WORD_W +: WORD_W];
                default: a = r.addr + addr_t'(lane) * addr_t'(4);
            endcase
        end
        return a;
    endfunction

    // ----------------------------------------------------------
    // Acceptance
    // ----------------------------------------------------------
    assign room      = !req.is_load || !tag_full; // Full FIFO holds back loads only
    assign req_ready = (state == IDLE) && global_req_ready && room;
    assign accept    = req_valid && req_ready;

    assign tag_push         = accept && req.is_load;
    assign tag_in.is_vector = req.is_vector;
    assign tag_in.is_tex    = req.is_tex;
    assign tag_in.rd        = req.rd;

    assign active = (state != IDLE);

    // ----------------------------------------------------------
    // Beat drive
    // ----------------------------------------------------------
    always_comb begin
        if (state == IDLE) begin
            // Beat 0 goes out in the accepting cycle
            global_req_valid   = req_valid && room;
            global_req_is_load = req.is_load;
            global_req_addr    = lane_addr(req, '0);
            global_req_wdata   = req.wdata[WORD_W-1:0];
        end else begin
            global_req_valid   = 1'b1;
            global_req_is_load = hold.is_load;
            global_req_addr    = lane_addr(hold, beat);
            global_req_wdata   = hold.wdata[beat*WORD_W +: WORD_W];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept && req.is_vector) begin
                        state <= BEATS;
                        beat  <= lane_t'(1);
                    end
                end
                BEATS: begin
                    if (global_req_ready) begin
                        if (beat == lane_t'(LANES - 1)) begin
                            state <= IDLE;
                        end
                        beat <= beat + 1'b1; // Wraps back to 0 after the last lane
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && req.is_vector) begin
            hold <= req;
        end
    end

endmodule

// File: hdl/lsu_load_tag_fifo.sv
module lsu_load_tag_fifo
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      push,
    input  load_tag_t tag_in,
    input  logic      pop,
    output load_tag_t tag_out,
    output logic      tag_valid,
    output logic      full
);

    load_tag_t            mem [TAG_DEPTH];
    logic [TAG_PTR_W-1:0] wr_ptr;
    logic [TAG_PTR_W-1:0] rd_ptr;
    logic [TAG_PTR_W:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign full      = (count == (TAG_PTR_W + 1)'(TAG_DEPTH));
    assign tag_valid = (count != '0);
    assign tag_out   = mem[rd_ptr];

    assign do_push = push && !full;
    assign do_pop  = pop && tag_valid;

    // Power-of-two depth, so pointers wrap on their own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= tag_in;
        end
    end

endmodule

// File: hdl/lsu_resp_assembler.sv
module lsu_resp_assembler
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      global_resp_valid,
    input  word_t     global_resp_data,
    input  load_tag_t tag_out,
    input  logic      tag_valid,
    output logic      pop,
    output logic      rsp_valid,
    output load_rsp_t rsp
);

    localparam lane_t LAST = lane_t'(LANES - 1);

    lane_t cnt;                // Beats already collected for the head vector
    word_t part [LANES-1];     // Lanes 0 to 2
    logic  beat_in;
    logic  last_beat;
    vec_t  vec_data;

    // Beats with no outstanding tag are dropped
    assign beat_in   = global_resp_valid && tag_valid;
    assign last_beat = !tag_out.is_vector || (cnt == LAST);

    assign pop       = beat_in && last_beat;
    assign rsp_valid = pop;

    // ----------------------------------------------------------
    // Vector reassembly
    // ----------------------------------------------------------
    always_comb begin
        vec_data = '0;
        for (int i = 0; i < LANES - 1; i++) begin
            vec_data[i*WORD_W +: WORD_W] = part[i];
        end
        vec_data[(LANES-1)*WORD_W +: WORD_W] = global_resp_data; // Final beat passes through
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (beat_in && tag_out.is_vector) begin
            cnt <= cnt + 1'b1; // Wraps to 0 on the fourth beat
        end
    end

    always_ff @(posedge clk) begin
        if (beat_in && tag_out.is_vector && (cnt != LAST)) begin
            part[cnt] <= global_resp_data;
        end
    end

    // ----------------------------------------------------------
    // Completed load
    // ----------------------------------------------------------
    assign rsp.is_vector = tag_out.is_vector;
    assign rsp.is_tex    = tag_out.is_tex;
    assign rsp.rd        = tag_out.rd;
    assign rsp.data      = tag_out.is_vector ? vec_data : vec_t'(global_resp_data);

endmodule

// File: hdl/lsu_global_top.sv
module lsu_global_top
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Pipeline
    input  logic      valid_in,
    input  logic      is_vector,
    input  logic      is_store,
    input  vec_mode_e vec_mode,
    input  addr_t     vec_stride,
    input  vec_t      vec_index,
    input  addr_t     addr,
    input  vec_t      write_data,
    input  reg_idx_t  dest_reg_idx,
    output logic      stall_pipeline,
    output logic      busy,
    // Texture refill
    input  logic      tex_req_valid,
    input  addr_t     tex_req_addr,
    output logic      tex_req_ready,
    output logic      tex_resp_valid,
    output vec_t      tex_resp_data,
    // External memory
    output logic      global_req_valid,
    output logic      global_req_is_load,
    output addr_t     global_req_addr,
    output word_t     global_req_wdata,
    input  logic      global_req_ready,
    input  logic      global_resp_valid,
    input  word_t     global_resp_data,
    // Register writeback
    output logic      wb_valid,
    output logic      wb_is_vector,
    output reg_idx_t  wb_reg_idx,
    output vec_t      wb_data
);

    mem_req_t  req;
    logic      req_valid;
    logic      req_ready;
    load_rsp_t rsp;
    logic      rsp_valid;
    logic      scalar_wait;
    logic      adapt_active;
    logic      tag_push;
    logic      tag_pop;
    logic      tag_full;
    logic      tag_valid;
    load_tag_t tag_in;
    load_tag_t tag_out;

    lsu_issue u_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_in       (valid_in),
        .is_vector      (is_vector),
        .is_store       (is_store),
        .vec_mode       (vec_mode),
        .vec_stride     (vec_stride),
        .vec_index      (vec_index),
        .addr           (addr),
        .write_data     (write_data),
        .dest_reg_idx   (dest_reg_idx),
        .tex_req_valid  (tex_req_valid),
        .tex_req_addr   (tex_req_addr),
        .req_ready      (req_ready),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .req_valid      (req_valid),
        .req            (req),
        .tex_req_ready  (tex_req_ready),
        .stall_pipeline (stall_pipeline),
        .scalar_wait    (scalar_wait)
    );

    lsu_beat_adapter u_adapter (
        .clk                (clk),
        .rst_n              (rst_n),
        .req_valid          (req_valid),
        .req                (req),
        .global_req_ready   (global_req_ready),
        .tag_full           (tag_full),
        .req_ready          (req_ready),
        .global_req_valid   (global_req_valid),
        .global_req_is_load (global_req_is_load),
        .global_req_addr    (global_req_addr),
        .global_req_wdata   (global_req_wdata),
        .tag_push           (tag_push),
        .tag_in             (tag_in),
        .active             (adapt_active)
    );

    lsu_load_tag_fifo u_tag_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tag_push),
        .tag_in    (tag_in),
        .pop       (tag_pop),
        .tag_out   (tag_out),
        .tag_valid (tag_valid),
        .full      (tag_full)
    );

    lsu_resp_assembler u_assembler (
        .clk               (clk),
        .rst_n             (rst_n),
        .global_resp_valid (global_resp_valid),
        .global_resp_data  (global_resp_data),
        .tag_out           (tag_out),
        .tag_valid         (tag_valid),
        .pop               (tag_pop),
        .rsp_valid         (rsp_valid),
        .rsp               (rsp)
    );

    // Route finished loads by source
    assign wb_valid       = rsp_valid && !rsp.is_tex;
    assign wb_is_vector   = rsp.is_vector;
    assign wb_reg_idx     = rsp.rd;
    assign wb_data        = rsp.data;
    assign tex_resp_valid = rsp_valid && rsp.is_tex;
    assign tex_resp_data  = rsp.data;

    assign busy = adapt_active || tag_valid || scalar_wait; // Anything in flight

endmodule

// File: tb/lsu_global_asserts.sv
module lsu_global_asserts
    import lsu_cfg_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  global_req_valid,
    input logic  global_req_ready,
    input addr_t global_req_addr,
    input word_t global_req_wdata,
    input logic  tex_resp_valid,
    input logic  wb_valid,
    input logic  stall_pipeline
);

    int fail_count;  // Watched by the testbench

    initial fail_count = 0;

    // ----------------------------------------------------------
    // External port
    // ----------------------------------------------------------
    a_beat_hold : assert property (@(posedge clk) disable iff (!rst_n)
        global_req_valid && !global_req_ready
        |=> $stable(global_req_addr) && $stable(global_req_wdata))
    else begin
        fail_count++;
        $error("beat changed while waiting for ready");
    end

    // Each finished load has one destination
    a_one_route : assert property (@(posedge clk) !(tex_resp_valid && wb_valid))
    else begin
        fail_count++;
        $error("texture return and writeback in the same cycle");
    end

    a_reset_stall : assert property (@(posedge clk) !rst_n |-> !stall_pipeline)
    else begin
        fail_count++;
        $error("stall raised during reset");
    end

endmodule

bind lsu_global_top lsu_global_asserts u_asserts (
    .clk              (clk),
    .rst_n            (rst_n),
    .global_req_valid (global_req_valid),
    .global_req_ready (global_req_ready),
    .global_req_addr  (global_req_addr),
    .global_req_wdata (global_req_wdata),
    .tex_resp_valid   (tex_resp_valid),
    .wb_valid         (wb_valid),
    .stall_pipeline   (stall_pipeline)
);

// File: tb/tb_lsu_global.sv
module tb_lsu_global
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
();

    localparam int    SEED       = 21749;
    localparam int    WAIT_LIMIT = 400;        // Cycles allowed per wait loop
    localparam int    MEM_WORDS  = 1024;
    localparam int    MEM_BYTES  = MEM_WORDS * 4;
    localparam word_t MAGIC      = 32'hA5C3_0F00;
    localparam int    BURST      = 8;
    localparam int    N_OPS      = 8 + BURST;
    localparam vec_t  VEC_DATA   = 128'hD3D3_0003_C2C2_0002_B1B1_0001_A0A0_0000;

    typedef enum logic [2:0] {
        ST_SCALAR, LD_SCALAR, ST_VECTOR, LD_VECTOR,
        TEX_LOAD   // Refill paired with the pipeline op in the next row
    } op_kind_e;

    typedef struct packed {
        op_kind_e  kind;
        vec_mode_e mode;
        logic      chain;  // Next op issues before this one completes
        reg_idx_t  rd;
        addr_t     addr;
        addr_t     stride;
        vec_t      index;
        vec_t      wdata;
        vec_t      exp;
    } op_t;

    typedef struct packed {
        logic     is_vector;
        reg_idx_t rd;
        vec_t     data;
    } wb_rec_t;

    logic clk, rst_n, valid_in, is_vector, is_store, stall_pipeline, busy;
    vec_mode_e vec_mode;
    addr_t     vec_stride, addr, tex_req_addr, global_req_addr;
    vec_t      vec_index, write_data, tex_resp_data, wb_data;
    reg_idx_t  dest_reg_idx, wb_reg_idx;
    logic      tex_req_valid, tex_req_ready, tex_resp_valid;
    logic      global_req_valid, global_req_is_load, global_req_ready, global_resp_valid;
    word_t     global_req_wdata, global_resp_data;
    logic      wb_valid, wb_is_vector;

    word_t   mem [MEM_WORDS];
    op_t     ops [N_OPS];
    string   op_name [N_OPS];
    word_t   rsp_q[$];
    addr_t   beat_q[$], exp_beat_q[$];
    wb_rec_t wb_q[$], exp_wb_q[$];
    vec_t    tex_q[$], exp_tex_q[$];
    string   beat_name_q[$], wb_name_q[$], tex_name_q[$];

    lsu_global_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Reference rules
    // ----------------------------------------------------------
    function automatic word_t preset(input addr_t a);
        return a ^ MAGIC;
    endfunction

    function automatic addr_t lane_at(input op_t op, input int l);
        addr_t base;
        addr_t offs;
        base = {op.addr[ADDR_W-1:4], 4'h0};
        offs = addr_t'(4 * l);                               // Unit stride, also texture
        if (op.kind == ST_SCALAR || op.kind == LD_SCALAR) begin
            base = op.addr;
            offs = '0;
        end else if (op.kind != TEX_LOAD && op.mode == STRIDE) begin
            offs = op.stride * addr_t'(l);
        end else if (op.kind != TEX_LOAD && op.mode == INDEXED) begin
            offs = op.index[l*WORD_W +: WORD_W];
        end
        return base + offs;
    endfunction

    task automatic check_value(input string name, input logic [VEC_W-1:0] exp,
                               input logic [VEC_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Bound checker failures end the run at once
    always @(negedge clk) begin
        if (u_dut.u_asserts.fail_count != 0) begin
            abort_run("a concurrent assertion on the DUT failed");
        end
    end

    // ----------------------------------------------------------
    // Operation table
    // ----------------------------------------------------------
    task automatic set_op(input int i, input string name, input op_kind_e kind,
                          input vec_mode_e mode, input addr_t base, input addr_t stride,
                          input vec_t index, input vec_t wdata, input reg_idx_t rd,
                          input logic chain);
        op_t op;
        op = '{kind: kind, mode: mode, chain: chain, rd: rd, addr: base, stride: stride,
               index: index, wdata: wdata, exp: '0};
        if (kind == LD_SCALAR) op.exp = vec_t'(preset(base));
        else for (int l = 0; l < LANES; l++) op.exp[l*WORD_W +: WORD_W] = preset(lane_at(op, l));
        ops[i]     = op;
        op_name[i] = name;
    endtask

    task automatic build_table();
        set_op(0, "scalar_store", ST_SCALAR, UNIT, 32'h040, '0, '0,
               128'hFFFF_FFFF_FFFF_FFFF_FFFF_FFFF_1234_5678, 5'd0, 1'b0);
        set_op(1, "scalar_load", LD_SCALAR, UNIT, 32'h040, '0, '0, '0, 5'd7, 1'b0);
        ops[1].exp = 128'h1234_5678;                         // Upper bits dropped by the store
        set_op(2, "vector_store", ST_VECTOR, UNIT, 32'h100, '0, '0, VEC_DATA, 5'd0, 1'b0);
        set_op(3, "vector_load", LD_VECTOR, UNIT, 32'h100, '0, '0, '0, 5'd3, 1'b0);
        ops[3].exp = VEC_DATA;
        set_op(4, "strided_load", LD_VECTOR, STRIDE, 32'h200, 32'h24, '0, '0, 5'd9, 1'b0);
        set_op(5, "indexed_load", LD_VECTOR, INDEXED, 32'h300, '0,
               {32'h10, 32'h04, 32'h3C, 32'h08}, '0, 5'd12, 1'b0);
        set_op(6, "tex_refill", TEX_LOAD, UNIT, 32'h400, '0, '0, '0, 5'd0, 1'b0);
        set_op(7, "load_behind_tex", LD_VECTOR, UNIT, 32'h500, '0, '0, '0, 5'd14, 1'b0);
        for (int k = 0; k < BURST; k++) begin
            set_op(8 + k, $sformatf("burst_%0d", k), LD_VECTOR, vec_mode_e'(k % 3),
                   32'h800 + 32'h40 * k, 32'h10 + 4 * k, {32'h0C, 32'h18, 32'h00, 32'h2C},
                   '0, reg_idx_t'(16 + k), k != BURST - 1);
        end
    endtask

    // ----------------------------------------------------------
    // Memory model
    // ----------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && global_req_valid && global_req_ready) begin
            if (global_req_addr >= addr_t'(MEM_BYTES) || global_req_addr[1:0] != 2'b00)
                abort_run($sformatf("beat address %h lies outside the memory", global_req_addr));
            beat_q.push_back(global_req_addr);
            if (global_req_is_load) rsp_q.push_back(mem[global_req_addr[11:2]]);
            else mem[global_req_addr[11:2]] = global_req_wdata;
        end
        if (wb_valid) wb_q.push_back({wb_is_vector, wb_reg_idx, wb_data});
        if (tex_resp_valid) tex_q.push_back(tex_resp_data);
    end

    initial begin
        int gap;
        void'($urandom(SEED));
        gap               = 0;
        global_req_ready  = 1'b0;
        global_resp_valid = 1'b0;
        global_resp_data  = '0;
        for (int w = 0; w < MEM_WORDS; w++) mem[w] = preset(addr_t'(w * 4));
        forever begin
            @(posedge clk);
            #1;
            global_req_ready  = ($urandom_range(9, 0) < 7); // Ready about 70% of cycles
            global_resp_valid = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (rsp_q.size() > 0) begin
                global_resp_valid = 1'b1;
                global_resp_data  = rsp_q.pop_front();
                gap               = $urandom_range(3, 0);
            end
        end
    end

    // ----------------------------------------------------------
    // Pipeline and texture drive
    // ----------------------------------------------------------
    task automatic drive_pipe(input int i);
        is_vector    = (ops[i].kind == ST_VECTOR || ops[i].kind == LD_VECTOR);
        is_store     = (ops[i].kind == ST_SCALAR || ops[i].kind == ST_VECTOR);
        vec_mode     = ops[i].mode;
        vec_stride   = ops[i].stride;
        vec_index    = ops[i].index;
        addr         = ops[i].addr;
        write_data   = ops[i].wdata;
        dest_reg_idx = ops[i].rd;
        valid_in     = 1'b1;
    endtask

    task automatic expect_op(input int i);
        int n;
        n = (ops[i].kind == ST_SCALAR || ops[i].kind == LD_SCALAR) ? 1 : LANES;
        for (int l = 0; l < n; l++) begin
            exp_beat_q.push_back(lane_at(ops[i], l));
            beat_name_q.push_back({op_name[i], " beat"});
        end
        if (ops[i].kind == TEX_LOAD) begin
            exp_tex_q.push_back(ops[i].exp);
            tex_name_q.push_back(op_name[i]);
        end else if (ops[i].kind == LD_SCALAR || ops[i].kind == LD_VECTOR) begin
            exp_wb_q.push_back({ops[i].kind == LD_VECTOR, ops[i].rd, ops[i].exp});
            wb_name_q.push_back(op_name[i]);
        end
    endtask

    // A scalar load stalls in its own issue cycle, so its beat marks acceptance
    task automatic wait_pipe_accept(input int i);
        int   t;
        logic done;
        t    = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            t++;
            if (ops[i].kind == LD_SCALAR)
                done = global_req_valid && global_req_ready && !tex_req_valid;
            else
                done = !stall_pipeline;
            if (!done && t > WAIT_LIMIT) abort_run({op_name[i], " was never accepted"});
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_tex_pair(input int i);
        int   t;
        logic done;
        t             = 0;
        done          = 1'b0;
        tex_req_addr  = ops[i].addr;
        tex_req_valid = 1'b1;
        drive_pipe(i + 1);
        expect_op(i);
        expect_op(i + 1);
        while (!done) begin
            @(negedge clk);
            t++;
            check_value({op_name[i + 1], " stalled behind refill"}, 1'b1, stall_pipeline);
            done = tex_req_ready;
            if (!done && t > WAIT_LIMIT) abort_run({op_name[i], " was never granted"});
        end
        @(posedge clk);
        #1;
        tex_req_valid = 1'b0;
        wait_pipe_accept(i + 1);
    endtask

    // Waits for the unit to go idle, then compares everything it produced
    task automatic drain();
        int      t;
        string   name;
        wb_rec_t e;
        wb_rec_t a;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (busy && t > WAIT_LIMIT) abort_run("unit stayed busy after the last request");
        end while (busy);
        check_value("beat count", exp_beat_q.size(), beat_q.size());
        while (exp_beat_q.size() > 0) begin
            name = beat_name_q.pop_front();
            check_value(name, exp_beat_q.pop_front(), beat_q.pop_front());
        end
        check_value("writeback count", exp_wb_q.size(), wb_q.size());
        while (exp_wb_q.size() > 0) begin
            name = wb_name_q.pop_front();
            e    = exp_wb_q.pop_front();
            a    = wb_q.pop_front();
            check_value({name, " is_vector"}, e.is_vector, a.is_vector);
            check_value({name, " rd"}, e.rd, a.rd);
            check_value({name, " data"}, e.data, a.data);
        end
        check_value("texture return count", exp_tex_q.size(), tex_q.size());
        while (exp_tex_q.size() > 0) begin
            name = tex_name_q.pop_front();
            check_value({name, " data"}, exp_tex_q.pop_front(), tex_q.pop_front());
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int i;
        rst_n         = 1'b0;
        valid_in      = 1'b0;
        is_vector     = 1'b0;
        is_store      = 1'b0;
        vec_mode      = UNIT;
        vec_stride    = '0;
        vec_index     = '0;
        addr          = '0;
        write_data    = '0;
        dest_reg_idx  = '0;
        tex_req_valid = 1'b0;
        tex_req_addr  = '0;
        build_table();
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_value("reset stall_pipeline", 1'b0, stall_pipeline);
        check_value("reset busy", 1'b0, busy);
        check_value("reset global_req_valid", 1'b0, global_req_valid);
        check_value("reset wb_valid", 1'b0, wb_valid);
        check_value("reset tex_resp_valid", 1'b0, tex_resp_valid);
        check_value("reset tex_req_ready", 1'b0, tex_req_ready);
        @(posedge clk);
        #1;
        i = 0;
        while (i < N_OPS) begin
            if (ops[i].kind == TEX_LOAD) begin
                run_tex_pair(i);
                i = i + 2;
            end else begin
                drive_pipe(i);
                expect_op(i);
                wait_pipe_accept(i);
                i = i + 1;
            end
            if (!ops[i - 1].chain) begin
                valid_in = 1'b0;
                drain();
                @(posedge clk);
                #1;
            end
        end
        if (u_dut.u_asserts.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1);
        end
    end

endmodule

// File: sim.f
hdl/lsu_cfg_pkg.sv
hdl/lsu_bus_pkg.sv
hdl/lsu_issue.sv
hdl/lsu_beat_adapter.sv
hdl/lsu_load_tag_fifo.sv
hdl/lsu_resp_assembler.sv
hdl/lsu_global_top.sv
tb/lsu_global_asserts.sv
tb/tb_lsu_global.sv

// File: Bender.yml
package:
  name: lsu_global

sources:
  - files:
      - hdl/lsu_cfg_pkg.sv
      - hdl/lsu_bus_pkg.sv
      - hdl/lsu_issue.sv
      - hdl/lsu_beat_adapter.sv
      - hdl/lsu_load_tag_fifo.sv
      - hdl/lsu_resp_assembler.sv
      - hdl/lsu_global_top.sv
  - target: simulation
    files:
      - tb/lsu_global_asserts.sv
      - tb/tb_lsu_global.sv
